// ==== logic/bus_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module bus_sequencer import soc_bus_pkg::*; (
    input  wire        clock_1hz,
    input  wire        KEY0,
    input  wire addr_t    bus_address,
    input  wire dword_t   bus_write_data,
    input  wire ls_type_t bus_ls_type,
    input  wire        bus_read_enable,
    input  wire        bus_write_enable,
    input  wire dword_t   ram_read_data,
    input  wire        ram_valid,
    input  wire word_t    plic_read_data,
    input  wire        plic_valid,
    output dword_t     bus_read_data,
    output logic       bus_read_done,
    output logic       bus_write_done,
    output logic       ram_start,
    output logic       ram_write,
    output ram_index_t ram_index,
    output byte_off_t  ram_offset,
    output ls_type_t   ram_ls_type,
    output dword_t     ram_write_data,
    output logic       plic_start,
    output logic       plic_write,
    output plic_off_t  plic_offset,
    output word_t      plic_write_data
);

    typedef enum logic [1:0] {IDLE, ISSUE, WAIT, FINISH} seq_state_t;

    seq_state_t state;
    logic       req_write;
    logic       req_ram;
    logic       req_plic;
    addr_t      ram_rel;
    addr_t      plic_rel;
    logic       ram_hit;
    logic       plic_hit;
    logic       accept;
    logic       complete;
    dword_t     result;

    // unsigned wrap makes addresses below a base miss as well
    assign ram_rel  = bus_address - RAM_BASE;
    assign plic_rel = bus_address - PLIC_BASE;
    assign ram_hit  = ram_rel < addr_t'(RAM_BYTES);
    assign plic_hit = plic_rel < addr_t'(PLIC_SPAN);

    assign accept = (state == IDLE) && (bus_read_enable || bus_write_enable);

    // unmapped accesses finish through FINISH with zero data
    assign complete = ((state == WAIT) && (ram_valid || plic_valid)) || (state == FINISH);

    always_comb begin
        if (req_ram) begin
            result = ram_read_data;
        end else if (req_plic) begin
            result = dword_t'(plic_read_data);   // zero extended
        end else begin
            result = '0;
        end
    end

    assign ram_write  = req_write;
    assign plic_write = req_write;

    // request payload, held for the whole access
    always_ff @(posedge clock_1hz) begin
        if (accept) begin
            ram_index       <= ram_rel[$clog2(RAM_BYTES)-1:2];
            ram_offset      <= bus_address[1:0];
            ram_ls_type     <= bus_ls_type;
            ram_write_data  <= bus_write_data;
            plic_offset     <= plic_rel[23:0];
            plic_write_data <= bus_write_data[31:0];
        end
    end

    always_ff @(posedge clock_1hz or negedge KEY0) begin
        if (!KEY0) begin
            state          <= IDLE;
            req_write      <= 1'b0;
            req_ram        <= 1'b0;
            req_plic       <= 1'b0;
            ram_start      <= 1'b0;
            plic_start     <= 1'b0;
            bus_read_done  <= 1'b1;
            bus_write_done <= 1'b1;
            bus_read_data  <= '0;
        end else begin
            ram_start  <= 1'b0;
            plic_start <= 1'b0;
            case (state)
                IDLE: if (accept) begin
                    req_write  <= bus_write_enable && !bus_read_enable;   // read wins
                    req_ram    <= ram_hit;
                    req_plic   <= plic_hit;
                    ram_start  <= ram_hit;
                    plic_start <= plic_hit;
                    if (bus_read_enable) begin
                        bus_read_done <= 1'b0;
                    end else begin
                        bus_write_done <= 1'b0;
                    end
                    state <= ISSUE;
                end
                ISSUE: state <= (req_ram || req_plic) ? WAIT : FINISH;
                WAIT, FINISH: if (complete) begin
                    if (req_write) begin
                        bus_write_done <= 1'b1;
                    end else begin
                        bus_read_data <= result;
                        bus_read_done <= 1'b1;
                    end
                    state <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    // master must wait for both done flags before the next strobe
    a_strobe_when_idle: assert property (@(posedge clock_1hz) disable iff (!KEY0)
        (bus_read_enable || bus_write_enable) |-> (bus_read_done && bus_write_done));

    a_strobe_exclusive: assert property (@(posedge clock_1hz) disable iff (!KEY0)
        !(bus_read_enable && bus_write_enable));

    // targets only answer an access we issued
    a_valid_in_wait: assert property (@(posedge clock_1hz) disable iff (!KEY0)
        (ram_valid || plic_valid) |-> (state == WAIT));

    a_plic_turnaround: assert property (@(posedge clock_1hz) disable iff (!KEY0)
        plic_start |=> plic_valid);

endmodule

`default_nettype wire

// ==== logic/plic_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module plic_regs import soc_bus_pkg::*; (
    input  wire        clock_1hz,
    input  wire        KEY0,
    input  wire        start,
    input  wire        write,
    input  wire plic_off_t offset,
    input  wire word_t     write_data,
    input  wire        irq_source,
    output word_t      read_data,
    output logic       valid,
    output logic       meip_interrupt,
    output logic       msip_interrupt
);

    localparam int PRIO_IDX_BITS = $clog2(PLIC_SOURCES);

    logic [PRIO_BITS-1:0] prio [PLIC_SOURCES];
    word_t                pending;
    word_t                enable [2];
    logic [PRIO_BITS-1:0] threshold [2];

    logic                     irq_d;
    logic                     prio_hit;
    logic [PRIO_IDX_BITS-1:0] prio_idx;
    logic                     pending_sel;
    logic [1:0]               enable_sel;
    logic [1:0]               thresh_sel;
    logic [1:0]               claim_sel;
    word_t                    claim_id [2];
    word_t                    rd_mux;

    // priority slots live at 4*id, ids past the last source fall through to zero
    assign prio_hit    = offset < plic_off_t'(4 * PLIC_SOURCES);
    assign prio_idx    = offset[PRIO_IDX_BITS+1:2];
    assign pending_sel = offset == PLIC_PENDING_OFF;

    always_comb begin
        for (int c = 0; c < 2; c++) begin
            enable_sel[c] = offset == PLIC_ENABLE_OFF + plic_off_t'(c) * PLIC_CTX_ENABLE_STRIDE;
            thresh_sel[c] = offset == PLIC_THRESHOLD_OFF + plic_off_t'(c) * PLIC_CTX_STRIDE;
            claim_sel[c]  = offset == PLIC_CLAIM_OFF + plic_off_t'(c) * PLIC_CTX_STRIDE;
        end
    end

    // single source, so the claim is just pending & enable
    always_comb begin
        for (int c = 0; c < 2; c++) begin
            claim_id[c] = (pending[IRQ_ID] && enable[c][IRQ_ID]) ? word_t'(IRQ_ID) : '0;
        end
    end

    assign meip_interrupt = claim_id[0] != '0;   // context 0
    assign msip_interrupt = claim_id[1] != '0;   // context 1

    // read mux, unlisted offsets return zero
    always_comb begin
        rd_mux = '0;
        if (prio_hit) begin
            rd_mux = word_t'(prio[prio_idx]);
        end else if (pending_sel) begin
            rd_mux = pending;
        end
        for (int c = 0; c < 2; c++) begin
            if (enable_sel[c]) rd_mux = enable[c];
            if (thresh_sel[c]) rd_mux = word_t'(threshold[c]);
            if (claim_sel[c])  rd_mux = claim_id[c];
        end
    end

    always_ff @(posedge clock_1hz) begin
        if (start && !write) begin
            read_data <= rd_mux;
        end
    end

    always_ff @(posedge clock_1hz or negedge KEY0) begin
        if (!KEY0) begin
            prio      <= '{default: '0};
            pending   <= '0;
            enable    <= '{default: '0};
            threshold <= '{default: '0};
            irq_d     <= 1'b0;
            valid     <= 1'b0;
        end else begin
            valid <= start;   // fixed one cycle turnaround
            irq_d <= irq_source;

            if (start && write) begin
                if (prio_hit) prio[prio_idx] <= write_data[PRIO_BITS-1:0];
                for (int c = 0; c < 2; c++) begin
                    if (enable_sel[c]) enable[c]    <= write_data;
                    if (thresh_sel[c]) threshold[c] <= write_data[PRIO_BITS-1:0];
                end
            end

            // claim read retires the pending bit, claim write is ignored
            if (start && !write) begin
                for (int c = 0; c < 2; c++) begin
                    if (claim_sel[c] && claim_id[c] != '0) pending[claim_id[c]] <= 1'b0;
                end
            end

            // new edge wins over a claim in the same cycle
            if (irq_source && !irq_d) begin
                pending[IRQ_ID] <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/ram_port.sv ====
`timescale 1ns/1ps
`default_nettype none

module ram_port import soc_bus_pkg::*; (
    input  wire        clock_1hz,
    input  wire        KEY0,
    input  wire        start,
    input  wire        write,
    input  wire ram_index_t index,
    input  wire byte_off_t  offset,
    input  wire ls_type_t   ls_type,
    input  wire dword_t     write_data,
    output dword_t     read_data,
    output logic       valid
);

    word_t mem [RAM_WORDS];

    logic       phase2;      // second word of ld/sd
    ram_index_t addr;
    logic [3:0] lane_en;
    word_t      lane_data;
    word_t      rd_word;     // registered read port
    word_t      lo_word;     // low half of ld
    word_t      shifted;

    // second phase walks to the next word, index itself is held upstream
    assign addr = phase2 ? index + ram_index_t'(1) : index;

    // byte lane enables and replicated write data
    always_comb begin
        lane_en   = '0;
        lane_data = write_data[31:0];
        if (phase2) begin
            lane_en   = {4{write}};
            lane_data = write_data[63:32];   // high word of sd
        end else if (start && write) begin
            case (ls_type)
                LS_B: begin
                    lane_en   = 4'b0001 << offset;
                    lane_data = {4{write_data[7:0]}};
                end
                LS_H: begin
                    // odd halfword offsets write nothing
                    if (offset == 2'd0) begin
                        lane_en = 4'b0011;
                    end else if (offset == 2'd2) begin
                        lane_en = 4'b1100;
                    end
                    lane_data = {2{write_data[15:0]}};
                end
                LS_W, LS_D: lane_en = 4'b1111;
                default: lane_en = '0;
            endcase
        end
    end

    // block ram with byte writes and one read port
    always_ff @(posedge clock_1hz) begin
        for (int i = 0; i < 4; i++) begin
            if (lane_en[i]) begin
                mem[addr][8*i +: 8] <= lane_data[8*i +: 8];
            end
        end
        rd_word <= mem[addr];
        if (phase2) begin
            lo_word <= rd_word;   // first word of ld arrived last cycle
        end
    end

    // sub-word extraction
    assign shifted = rd_word >> {offset, 3'b000};

    always_comb begin
        case (ls_type)
            LS_B:    read_data = {{56{shifted[7]}}, shifted[7:0]};
            LS_BU:   read_data = {56'd0, shifted[7:0]};
            LS_H:    read_data = {{48{shifted[15]}}, shifted[15:0]};
            LS_HU:   read_data = {48'd0, shifted[15:0]};
            LS_W:    read_data = {{32{shifted[31]}}, shifted};
            LS_WU:   read_data = {32'd0, shifted};
            LS_D:    read_data = {rd_word, lo_word};
            default: read_data = '0;
        endcase
    end

    // one cycle for single words, two for ld/sd
    always_ff @(posedge clock_1hz or negedge KEY0) begin
        if (!KEY0) begin
            phase2 <= 1'b0;
            valid  <= 1'b0;
        end else begin
            phase2 <= start && (ls_type == LS_D);
            valid  <= (start && (ls_type != LS_D)) || phase2;
        end
    end

    // a two-word access must not run off the end of the array
    a_dword_in_range: assert property (@(posedge clock_1hz) disable iff (!KEY0)
        (start && ls_type == LS_D) |-> (index != ram_index_t'(RAM_WORDS - 1)));

endmodule

`default_nettype wire

// ==== logic/soc_bus.sv ====
`timescale 1ns/1ps
`default_nettype none

module soc_bus import soc_bus_pkg::*; (
    input  wire        clock_1hz,
    input  wire        KEY0,
    input  wire addr_t    bus_address,
    input  wire dword_t   bus_write_data,
    input  wire ls_type_t bus_ls_type,
    input  wire        bus_read_enable,
    input  wire        bus_write_enable,
    input  wire        irq_source,
    output dword_t     bus_read_data,
    output logic       bus_read_done,
    output logic       bus_write_done,
    output logic       meip_interrupt,
    output logic       msip_interrupt
);

    // sequencer to scratch ram
    logic       ram_start;
    logic       ram_write;
    ram_index_t ram_index;
    byte_off_t  ram_offset;
    ls_type_t   ram_ls_type;
    dword_t     ram_write_data;
    dword_t     ram_read_data;
    logic       ram_valid;

    // sequencer to interrupt controller
    logic       plic_start;
    logic       plic_write;
    plic_off_t  plic_offset;
    word_t      plic_write_data;
    word_t      plic_read_data;
    logic       plic_valid;

    bus_sequencer bus_sequencer_i (
        .clock_1hz        (clock_1hz),
        .KEY0             (KEY0),
        .bus_address      (bus_address),
        .bus_write_data   (bus_write_data),
        .bus_ls_type      (bus_ls_type),
        .bus_read_enable  (bus_read_enable),
        .bus_write_enable (bus_write_enable),
        .ram_read_data    (ram_read_data),
        .ram_valid        (ram_valid),
        .plic_read_data   (plic_read_data),
        .plic_valid       (plic_valid),
        .bus_read_data    (bus_read_data),
        .bus_read_done    (bus_read_done),
        .bus_write_done   (bus_write_done),
        .ram_start        (ram_start),
        .ram_write        (ram_write),
        .ram_index        (ram_index),
        .ram_offset       (ram_offset),
        .ram_ls_type      (ram_ls_type),
        .ram_write_data   (ram_write_data),
        .plic_start       (plic_start),
        .plic_write       (plic_write),
        .plic_offset      (plic_offset),
        .plic_write_data  (plic_write_data)
    );

    ram_port ram_port_i (
        .clock_1hz  (clock_1hz),
        .KEY0       (KEY0),
        .start      (ram_start),
        .write      (ram_write),
        .index      (ram_index),
        .offset     (ram_offset),
        .ls_type    (ram_ls_type),
        .write_data (ram_write_data),
        .read_data  (ram_read_data),
        .valid      (ram_valid)
    );

    plic_regs plic_regs_i (
        .clock_1hz      (clock_1hz),
        .KEY0           (KEY0),
        .start          (plic_start),
        .write          (plic_write),
        .offset         (plic_offset),
        .write_data     (plic_write_data),
        .irq_source     (irq_source),
        .read_data      (plic_read_data),
        .valid          (plic_valid),
        .meip_interrupt (meip_interrupt),
        .msip_interrupt (msip_interrupt)
    );

endmodule

`default_nettype wire

// ==== logic/soc_bus_pkg.sv ====
`default_nettype none

package soc_bus_pkg;

    // bus side widths
    typedef logic [63:0] addr_t;
    typedef logic [63:0] dword_t;
    typedef logic [31:0] word_t;

    // scratch ram addressing
    typedef logic [8:0] ram_index_t;   // word index into 2 KB
    typedef logic [1:0] byte_off_t;    // byte within a word

    typedef logic [23:0] plic_off_t;   // offset from PLIC_BASE

    // load/store width, bit 2 selects the unsigned loads
    typedef enum logic [2:0] {
        LS_B  = 3'b000,
        LS_H  = 3'b001,
        LS_W  = 3'b010,
        LS_D  = 3'b011,
        LS_BU = 3'b100,
        LS_HU = 3'b101,
        LS_WU = 3'b110
    } ls_type_t;

    // scratch memory window
    localparam addr_t RAM_BASE  = 64'h8000_0000;
    localparam int    RAM_BYTES = 2048;
    localparam int    RAM_WORDS = 512;

    // interrupt controller window
    localparam addr_t     PLIC_BASE = 64'h0C00_0000;
    localparam plic_off_t PLIC_SPAN = 24'h40_0000;

    // register map inside the window
    localparam plic_off_t PLIC_PENDING_OFF       = 24'h00_1000;  // one bit per source
    localparam plic_off_t PLIC_ENABLE_OFF        = 24'h00_2000;  // per context bitmap
    localparam plic_off_t PLIC_CTX_ENABLE_STRIDE = 24'h00_0080;
    localparam plic_off_t PLIC_THRESHOLD_OFF     = 24'h20_0000;
    localparam plic_off_t PLIC_CLAIM_OFF         = 24'h20_0004;
    localparam plic_off_t PLIC_CTX_STRIDE        = 24'h00_1000;  // threshold and claim

    // priority slots 0..5 sit at offset 4*id
    localparam int PLIC_SOURCES = 6;
    localparam int PRIO_BITS    = 3;

    // the only wired source
    localparam int IRQ_ID = 1;

endpackage

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module soc_bus_tb -f tb.f -o soc_bus_sim
./obj_dir/soc_bus_sim

// ==== tb.f ====
logic/soc_bus_pkg.sv
logic/ram_port.sv
logic/plic_regs.sv
logic/bus_sequencer.sv
logic/soc_bus.sv
tb/tb_clock.sv
tb/soc_bus_tb.sv

// ==== tb/soc_bus_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module soc_bus_tb import soc_bus_pkg::*; ();

    localparam int CLK_NS       = 4;
    localparam int RAND_SEED    = 58069;
    localparam int LAT_WORD     = 2;
    localparam int LAT_DWORD    = 3;
    localparam int LAT_PLIC     = 2;
    localparam int LAT_UNMAPPED = 2;
    localparam int SW_PAIRS     = 16;
    localparam int SD_PAIRS     = 8;
    localparam int PRIO_SLOTS   = 8;   // two past the last source
    // reset, ram pairs, 18 sub-word accesses per offset, plic regs, irq, unmapped
    localparam int NUM_OPS = 2 + 2 * SW_PAIRS + 2 * SD_PAIRS + 4 * 18
                           + 2 * PRIO_SLOTS + 8 + 9 + 6;
    localparam word_t PRIO_MASK = word_t'((1 << PRIO_BITS) - 1);
    localparam word_t IRQ_BIT   = word_t'(1 << IRQ_ID);

    wire      clock_1hz;
    wire      KEY0;
    addr_t    bus_address;
    dword_t   bus_write_data;
    ls_type_t bus_ls_type;
    logic     bus_read_enable;
    logic     bus_write_enable;
    logic     irq_source;
    dword_t   bus_read_data;
    logic     bus_read_done;
    logic     bus_write_done;
    logic     meip_interrupt;
    logic     msip_interrupt;

    word_t  ram_model [RAM_WORDS];
    word_t  pending_model;
    word_t  enable_model [2];
    int     edge_count = 0;
    logic   busy = 1'b0;      // one access in flight
    logic   saw_low = 1'b0;   // done flag has fallen
    logic   exp_read;
    logic   exp_word;         // plic result, upper half zero
    dword_t exp_data;
    int     exp_latency;
    int     exp_edge;
    logic   done_now;

    tb_clock tb_clock_i (.clock_1hz(clock_1hz), .KEY0(KEY0));

    soc_bus soc_bus_i (
        .clock_1hz        (clock_1hz),
        .KEY0             (KEY0),
        .bus_address      (bus_address),
        .bus_write_data   (bus_write_data),
        .bus_ls_type      (bus_ls_type),
        .bus_read_enable  (bus_read_enable),
        .bus_write_enable (bus_write_enable),
        .irq_source       (irq_source),
        .bus_read_data    (bus_read_data),
        .bus_read_done    (bus_read_done),
        .bus_write_done   (bus_write_done),
        .meip_interrupt   (meip_interrupt),
        .msip_interrupt   (msip_interrupt)
    );

    task automatic abort_run(string reason);
        $display("%s", reason);
        $display("Test failed");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_dword(string name, dword_t expected, dword_t actual);
        if (actual !== expected) begin
            abort_run($sformatf("mismatch at time %0t: %s expected %h actual %h",
                                $time, name, expected, actual));
        end
    endtask

    task automatic check_word(string name, word_t expected, word_t actual);
        if (actual !== expected) begin
            abort_run($sformatf("mismatch at time %0t: %s expected %h actual %h",
                                $time, name, expected, actual));
        end
    endtask

    task automatic check_bit(string name, logic expected, logic actual);
        if (actual !== expected) begin
            abort_run($sformatf("mismatch at time %0t: %s expected %b actual %b",
                                $time, name, expected, actual));
        end
    endtask

    task automatic check_latency(string name, int expected, int actual);
        if (actual != expected) begin
            abort_run($sformatf("mismatch at time %0t: %s expected %0d actual %0d cycles",
                                $time, name, expected, actual));
        end
    endtask

    // shift by the byte offset, then extend by load type
    function automatic dword_t model_load(ram_index_t idx, byte_off_t off, ls_type_t t);
        word_t  sh;
        longint ext;
        sh = ram_model[idx] >> (8 * off);
        case (t)
            LS_B:    ext = $signed(sh[7:0]);
            LS_H:    ext = $signed(sh[15:0]);
            LS_W:    ext = $signed(sh);
            LS_BU:   ext = longint'(sh[7:0]);
            LS_HU:   ext = longint'(sh[15:0]);
            LS_WU:   ext = longint'(sh);
            LS_D:    ext = longint'({ram_model[int'(idx) + 1], ram_model[idx]});
            default: ext = 0;
        endcase
        return dword_t'(ext);
    endfunction

    function automatic word_t model_store(word_t old, ls_type_t t, byte_off_t off, dword_t data);
        word_t w;
        w = old;
        case (t)
            LS_B: w[8 * off +: 8] = data[7:0];
            LS_H: if (!off[0]) w[8 * off +: 16] = data[15:0];   // odd offset is dropped
            LS_W: w = data[31:0];
            default: w = old;
        endcase
        return w;
    endfunction

    function automatic word_t model_claim(word_t pending, word_t enable);
        return (pending[IRQ_ID] && enable[IRQ_ID]) ? word_t'(IRQ_ID) : word_t'(0);
    endfunction

    // strobe one access and block until the compare process has seen it finish
    task automatic issue_access(addr_t addr, ls_type_t t, dword_t data, logic is_read,
                                logic word_result, dword_t expected, int latency);
        @(posedge clock_1hz);
        #1;
        bus_address      = addr;
        bus_ls_type      = t;
        bus_write_data   = data;
        bus_read_enable  = is_read;
        bus_write_enable = !is_read;
        exp_read         = is_read;
        exp_word         = word_result;
        exp_data         = expected;
        exp_latency      = latency;
        exp_edge         = edge_count + 1;   // edge that samples the strobe
        saw_low          = 1'b0;
        busy             = 1'b1;
        @(posedge clock_1hz);
        #1;
        bus_read_enable  = 1'b0;
        bus_write_enable = 1'b0;
        wait (!busy);
    endtask

    task automatic store_ram(ram_index_t idx, byte_off_t off, ls_type_t t, dword_t data);
        if (t == LS_D) begin
            ram_model[idx]              = data[31:0];
            ram_model[int'(idx) + 1]    = data[63:32];
        end else begin
            ram_model[idx] = model_store(ram_model[idx], t, off, data);
        end
        issue_access(RAM_BASE + addr_t'({idx, off}), t, data, 1'b0, 1'b0, '0,
                     (t == LS_D) ? LAT_DWORD : LAT_WORD);
    endtask

    task automatic load_ram(ram_index_t idx, byte_off_t off, ls_type_t t);
        issue_access(RAM_BASE + addr_t'({idx, off}), t, '0, 1'b1, 1'b0,
                     model_load(idx, off, t), (t == LS_D) ? LAT_DWORD : LAT_WORD);
    endtask

    task automatic load_every_width(ram_index_t idx, byte_off_t off);
        load_ram(idx, off, LS_B);
        load_ram(idx, off, LS_BU);
        load_ram(idx, off, LS_H);
        load_ram(idx, off, LS_HU);
        load_ram(idx, off, LS_W);
        load_ram(idx, off, LS_WU);
        load_ram(idx, 2'd0, LS_W);   // whole word after the store
    endtask

    task automatic write_plic(plic_off_t off, word_t data);
        issue_access(PLIC_BASE + addr_t'(off), LS_W, dword_t'(data), 1'b0, 1'b1, '0, LAT_PLIC);
    endtask

    task automatic read_plic(plic_off_t off, word_t expected);
        issue_access(PLIC_BASE + addr_t'(off), LS_W, '0, 1'b1, 1'b1, dword_t'(expected),
                     LAT_PLIC);
    endtask

    task automatic pulse_irq();
        @(posedge clock_1hz);
        #1 irq_source = 1'b1;
        @(posedge clock_1hz);
        #1 irq_source = 1'b0;
    endtask

    always @(posedge clock_1hz) edge_count <= edge_count + 1;

    // compare process, samples on the falling edge
    always @(negedge clock_1hz) begin
        if (busy) begin
            // the other flag stays high for the whole access
            if (exp_read) begin
                check_bit("bus_write_done", 1'b1, bus_write_done);
            end else begin
                check_bit("bus_read_done", 1'b1, bus_read_done);
            end
            done_now = exp_read ? bus_read_done : bus_write_done;
            if (!done_now) begin
                saw_low = 1'b1;
            end else if (saw_low) begin
                check_latency("done latency", exp_latency, edge_count - exp_edge);
                if (exp_read && exp_word) begin
                    check_word("bus_read_data[31:0]", exp_data[31:0], bus_read_data[31:0]);
                    check_word("bus_read_data[63:32]", word_t'(0), bus_read_data[63:32]);
                end else if (exp_read) begin
                    check_dword("bus_read_data", exp_data, bus_read_data);
                end
                busy = 1'b0;
            end
        end
    end

    initial begin
        #(NUM_OPS * 8 * CLK_NS);
        abort_run("timeout: the bus accesses did not all finish in time");
    end

    initial begin
        ram_index_t idx;
        word_t      data;
        bus_address      = '0;
        bus_write_data   = '0;
        bus_ls_type      = LS_W;
        bus_read_enable  = 1'b0;
        bus_write_enable = 1'b0;
        irq_source       = 1'b0;
        pending_model    = '0;
        void'($urandom(RAND_SEED));

        @(posedge KEY0);
        @(negedge clock_1hz);
        check_bit("bus_read_done", 1'b1, bus_read_done);
        check_bit("bus_write_done", 1'b1, bus_write_done);
        check_dword("bus_read_data", '0, bus_read_data);
        check_bit("meip_interrupt", 1'b0, meip_interrupt);
        check_bit("msip_interrupt", 1'b0, msip_interrupt);

        for (int n = 0; n < SW_PAIRS; n++) begin
            idx = ram_index_t'($urandom_range(RAM_WORDS - 1));
            store_ram(idx, 2'd0, LS_W, {$urandom(), $urandom()});
            load_ram(idx, 2'd0, LS_W);
        end
        for (int n = 0; n < SD_PAIRS; n++) begin
            idx = ram_index_t'($urandom_range(RAM_WORDS - 2));   // room for the high word
            store_ram(idx, 2'd0, LS_D, {$urandom(), $urandom()});
            load_ram(idx, 2'd0, LS_D);
        end

        for (int o = 0; o < 4; o++) begin
            idx = ram_index_t'($urandom_range(RAM_WORDS - 1));
            store_ram(idx, 2'd0, LS_W, dword_t'($urandom()));
            store_ram(idx, byte_off_t'(o), LS_B, dword_t'($urandom()));
            load_every_width(idx, byte_off_t'(o));
            store_ram(idx, 2'd0, LS_W, dword_t'($urandom()));
            store_ram(idx, byte_off_t'(o), LS_H, dword_t'($urandom()));
            load_every_width(idx, byte_off_t'(o));
        end

        for (int id = 0; id < PRIO_SLOTS; id++) begin
            data = $urandom();
            write_plic(plic_off_t'(4 * id), data);
            read_plic(plic_off_t'(4 * id), (id < PLIC_SOURCES) ? (data & PRIO_MASK) : '0);
        end
        for (int c = 0; c < 2; c++) begin
            enable_model[c] = $urandom();
            write_plic(PLIC_ENABLE_OFF + plic_off_t'(c) * PLIC_CTX_ENABLE_STRIDE, enable_model[c]);
            read_plic(PLIC_ENABLE_OFF + plic_off_t'(c) * PLIC_CTX_ENABLE_STRIDE, enable_model[c]);
            data = $urandom();
            write_plic(PLIC_THRESHOLD_OFF + plic_off_t'(c) * PLIC_CTX_STRIDE, data);
            read_plic(PLIC_THRESHOLD_OFF + plic_off_t'(c) * PLIC_CTX_STRIDE, data & PRIO_MASK);
        end

        // source enabled in context 0 only
        enable_model[0] = IRQ_BIT;
        enable_model[1] = $urandom() & ~IRQ_BIT;
        write_plic(PLIC_ENABLE_OFF, enable_model[0]);
        write_plic(PLIC_ENABLE_OFF + PLIC_CTX_ENABLE_STRIDE, enable_model[1]);
        pulse_irq();
        pending_model[IRQ_ID] = 1'b1;
        @(negedge clock_1hz);
        check_bit("meip_interrupt", model_claim(pending_model, enable_model[0]) != 0,
                  meip_interrupt);
        check_bit("msip_interrupt", model_claim(pending_model, enable_model[1]) != 0,
                  msip_interrupt);
        read_plic(PLIC_PENDING_OFF, pending_model);
        data = model_claim(pending_model, enable_model[0]);
        read_plic(PLIC_CLAIM_OFF, data);
        if (data != 0) pending_model[data] = 1'b0;   // claim retires the source
        @(negedge clock_1hz);
        check_bit("meip_interrupt", model_claim(pending_model, enable_model[0]) != 0,
                  meip_interrupt);
        read_plic(PLIC_CLAIM_OFF, model_claim(pending_model, enable_model[0]));

        // unmapped reads return zero, the write aliases a ram word below the window
        issue_access(64'h4000_0000, LS_W, '0, 1'b1, 1'b0, '0, LAT_UNMAPPED);
        issue_access(RAM_BASE + addr_t'(RAM_BYTES), LS_D, '0, 1'b1, 1'b0, '0, LAT_UNMAPPED);
        issue_access(PLIC_BASE + addr_t'(PLIC_SPAN), LS_W, '0, 1'b1, 1'b0, '0, LAT_UNMAPPED);
        idx = ram_index_t'($urandom_range(RAM_WORDS - 1));
        store_ram(idx, 2'd0, LS_W, dword_t'($urandom()));
        issue_access(RAM_BASE - addr_t'(RAM_BYTES) + addr_t'({idx, 2'b00}), LS_W,
                     {$urandom(), $urandom()}, 1'b0, 1'b0, '0, LAT_UNMAPPED);
        load_ram(idx, 2'd0, LS_W);

        wait (!busy);
        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb/tb_clock.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic clock_1hz,
    output logic KEY0
);

    localparam int HALF_PERIOD_NS = 2;   // 4 ns period
    localparam int RESET_CYCLES   = 5;

    initial begin
        clock_1hz = 1'b0;
        forever #HALF_PERIOD_NS clock_1hz = ~clock_1hz;
    end

    // release just after an edge, like the rest of the stimulus
    initial begin
        KEY0 = 1'b0;
        repeat (RESET_CYCLES) @(posedge clock_1hz);
        #1 KEY0 = 1'b1;
    end

endmodule

`default_nettype wire
